// ==== list.f ====
host_mem_pkg.sv
afu_csr_pkg.sv
afu_csr.sv
host_rd_engine.sv
host_chan_events.sv
afu_top.sv
afu_assertions.sv
tb_afu_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the latency tester testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module tb_afu_top -f list.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_afu_top 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1

// ==== tb_afu_top.sv ====
//==========================================================
// Latency tester testbench
// Drives MMIO, models host memory with random stalls and
// delays, checks checksum, counts and latency
//==========================================================

`timescale 1ns/10ps

module tb_afu_top
    import host_mem_pkg::*;
    import afu_csr_pkg::*;
;

    localparam int MAX_OUTSTANDING = 4;
    localparam int TIMEOUT_CYCLES  = 20000;
    localparam int LANES           = LINE_DATA_WIDTH / 64;

    logic         clk;
    logic         arst_n;
    t_mmio_req    mmio_req;
    t_mmio_rsp    mmio_rsp;
    t_host_rd_rsp rd_rsp;
    t_host_rd_req rd_req;
    logic         waitrequest;

    integer     seed = 48138;
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests_run = 0;
    int         tests_passed = 0;
    bit         rand_mode = 1'b0;
    t_line_addr next_addr = '0;
    longint     lat_sum = 0;
    int         max_seen = 0;
    int         unanswered;

    // Accepted reads waiting for their response, oldest first
    t_line_addr pend_addr[$];
    int         pend_acc[$];
    int         pend_due[$];

    afu_top #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_afu_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .mmio_req    (mmio_req),
        .rd_rsp      (rd_rsp),
        .waitrequest (waitrequest),
        .mmio_rsp    (mmio_rsp),
        .rd_req      (rd_req)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    //==========================================================
    // Helpers
    //==========================================================

    // Every lane mixes the whole line address
    function automatic logic [LINE_DATA_WIDTH-1:0] line_data(input t_line_addr addr);
        logic [LINE_DATA_WIDTH-1:0] data;
        logic [63:0]                a;
        a = 64'(addr);
        for (int j = 0; j < LANES; j++)
            data[j*64 +: 64] = (a << j) ^ {a[31:0], a[63:32]} ^
                               (64'h9E37_79B9_7F4A_7C15 * 64'(j + 1));
        return data;
    endfunction

    // XOR of every 64-bit lane of lines base to base + count - 1
    function automatic logic [63:0] expected_checksum(input t_line_addr base, input int count);
        logic [63:0]                sum;
        logic [LINE_DATA_WIDTH-1:0] line;
        sum = '0;
        for (int i = 0; i < count; i++)
        begin
            line = line_data(base + t_line_addr'(i));
            for (int j = 0; j < LANES; j++)
                sum = sum ^ line[j*64 +: 64];
        end
        return sum;
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $realtime, name, actual, expected);
        end
    endtask

    task automatic mmio_write(input logic [2:0] addr, input logic [63:0] data);
        @(posedge clk);
        #1;
        mmio_req.write     = 1'b1;
        mmio_req.address   = addr;
        mmio_req.writedata = data;
        @(posedge clk);
        #1;
        mmio_req.write = 1'b0;
    endtask

    // Response must show up exactly one cycle after the strobe
    task automatic mmio_read(input logic [2:0] addr, output logic [63:0] data);
        @(posedge clk);
        #1;
        mmio_req.read    = 1'b1;
        mmio_req.address = addr;
        @(negedge clk);
        check("mmio_rsp.readdatavalid", 64'(mmio_rsp.readdatavalid), 64'd0);
        @(posedge clk);
        #1;
        mmio_req.read = 1'b0;
        @(negedge clk);
        check("mmio_rsp.readdatavalid", 64'(mmio_rsp.readdatavalid), 64'd1);
        data = mmio_rsp.readdata;
    endtask

    task automatic run_reads(input t_line_addr base, input int count, input bit random_wait);
        logic [63:0] status_word;
        rand_mode = random_wait;
        next_addr = base;
        lat_sum   = 0;
        max_seen  = 0;
        mmio_write(CSR_BASE, 64'(base));
        mmio_write(CSR_COUNT, 64'(count));
        mmio_write(CSR_CTRL, 64'd1);
        status_word = '0;
        while (!status_word[0])
            mmio_read(CSR_STATUS, status_word);
    endtask

    task automatic check_results(input t_line_addr base, input int count);
        logic [63:0] w;
        mmio_read(CSR_STATUS, w);
        check("status.done", 64'(w[0]), 64'd1);
        check("status.rsp_count", 64'(w[63:32]), 64'(count));
        mmio_read(CSR_CHECKSUM, w);
        check("checksum", w, expected_checksum(base, count));
    endtask

    task automatic check_latency();
        logic [63:0] w;
        mmio_read(CSR_LATENCY, w);
        check("latency", w, 64'(lat_sum));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
        begin
            tests_passed++;
            $display("Test %0d %s: passed", tests_run, name);
        end
        else
            $display("Test %0d %s: failed", tests_run, name);
    endtask

    //==========================================================
    // Host memory model
    //==========================================================

    initial
    begin : host_mem_model
        waitrequest = 1'b0;
        rd_rsp      = '0;
        forever
        begin
            @(posedge clk);
            #1;
            waitrequest = rand_mode && (($random(seed) & 3) == 0);
            if (pend_due.size() > 0 && pend_due[0] <= cycle)
            begin
                rd_rsp.readdatavalid = 1'b1;
                rd_rsp.readdata      = line_data(pend_addr[0]);
                lat_sum = lat_sum + longint'(cycle - pend_acc[0]);
                void'(pend_addr.pop_front());
                void'(pend_acc.pop_front());
                void'(pend_due.pop_front());
            end
            else
                rd_rsp = '0;
            @(negedge clk);
            if (rd_req.read && !waitrequest)
            begin
                check("rd_req.address", 64'(rd_req.address), 64'(next_addr));
                next_addr = next_addr + t_line_addr'(1);
                pend_addr.push_back(rd_req.address);
                pend_acc.push_back(cycle);
                pend_due.push_back(cycle + 2 + int'($unsigned($random(seed)) % 8));
                // The read answered in this cycle still counts as unanswered
                unanswered = pend_addr.size() + int'(rd_rsp.readdatavalid);
                if (unanswered > max_seen)
                    max_seen = unanswered;
            end
        end
    end

    initial
    begin : watchdog
        while (cycle < TIMEOUT_CYCLES)
            @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    //==========================================================
    // Test sequence
    //==========================================================

    initial
    begin : main_sequence
        logic [63:0] w;
        int          errors_before;
        $timeformat(-9, 1, " ns", 0);
        arst_n   = 1'b0;
        mmio_req = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        errors_before = errors;
        mmio_write(CSR_BASE, 64'h0000_02AB_CDEF_1234);
        mmio_write(CSR_COUNT, 64'h0000_0000_8000_0028);
        mmio_read(CSR_BASE, w);
        check("base register", w, 64'h0000_02AB_CDEF_1234);
        mmio_read(CSR_COUNT, w);
        check("count register", w, 64'h0000_0000_8000_0028);
        report_test("register readback", errors_before);

        errors_before = errors;
        run_reads(42'h000_0010_0000, 40, 1'b0);
        check_results(42'h000_0010_0000, 40);
        report_test("40 reads without waitrequest", errors_before);

        errors_before = errors;
        run_reads(42'h3FF_FFFF_FFC0, 100, 1'b1);
        check_results(42'h3FF_FFFF_FFC0, 100);
        checks++;
        if (max_seen > MAX_OUTSTANDING)
        begin
            errors++;
            $display("Memory model saw %0d unanswered reads, above the limit of %0d",
                     max_seen, MAX_OUTSTANDING);
        end
        report_test("100 reads with random stalls", errors_before);

        errors_before = errors;
        check_latency();
        report_test("latency total", errors_before);

        errors_before = errors;
        mmio_write(CSR_CTRL, 64'd2);
        mmio_read(CSR_STATUS, w);
        check("status after clear", w, 64'd0);
        mmio_read(CSR_CHECKSUM, w);
        check("checksum after clear", w, 64'd0);
        mmio_read(CSR_LATENCY, w);
        check("latency after clear", w, 64'd0);
        run_reads(42'h001_2345_6789, 25, 1'b1);
        check_results(42'h001_2345_6789, 25);
        check_latency();
        report_test("clear and second start", errors_before);

        $display("Tests passed: %0d of %0d, checks: %0d, errors: %0d",
                 tests_passed, tests_run, checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== afu_assertions.sv ====
//==========================================================
// Read engine assertions
// Avalon request stability, credit limit and reset state
//==========================================================

`timescale 1ns/10ps

module afu_assertions
    import host_mem_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 16,
    parameter int CREDIT_W        = $clog2(MAX_OUTSTANDING + 1)
)
(
    input logic                clk,
    input logic                arst_n,
    input t_host_rd_req        rd_req,
    input logic                waitrequest,
    input logic [CREDIT_W-1:0] outstanding,
    input logic                done
);

    // A stalled request keeps its strobe and address
    held_under_wait: assert property (@(posedge clk) disable iff (!arst_n)
        rd_req.read && waitrequest |=> rd_req.read && $stable(rd_req.address))
        else $error("read request changed while waitrequest was high");

    credit_limit: assert property (@(posedge clk) disable iff (!arst_n)
        outstanding <= CREDIT_W'(MAX_OUTSTANDING))
        else $error("outstanding reads exceed the credit limit");

    done_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !done)
        else $error("done is high out of reset");

endmodule

bind host_rd_engine afu_assertions #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
) i_afu_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .rd_req      (rd_req),
    .waitrequest (waitrequest),
    .outstanding (outstanding),
    .done        (done)
);

// ==== afu_top.sv ====
//==========================================================
// Latency tester top level
// Connects the MMIO register block, the host read engine
// and the event tracker
//==========================================================

`timescale 1ns/10ps

module afu_top
    import host_mem_pkg::*;
    import afu_csr_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 16
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  t_mmio_req    mmio_req,
    input  t_host_rd_rsp rd_rsp,
    input  logic         waitrequest,
    output t_mmio_rsp    mmio_rsp,
    output t_host_rd_req rd_req
);

    localparam int CNT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

    t_rd_cfg    cfg;
    t_rd_status status;
    logic       start;
    logic       clear;
    logic       accept;

    assign accept = rd_req.read && !waitrequest;

    afu_csr i_afu_csr (
        .clk      (clk),
        .arst_n   (arst_n),
        .mmio_req (mmio_req),
        .status   (status),
        .mmio_rsp (mmio_rsp),
        .cfg      (cfg),
        .start    (start),
        .clear    (clear)
    );

    host_rd_engine #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) i_host_rd_engine (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg         (cfg),
        .start       (start),
        .clear       (clear),
        .waitrequest (waitrequest),
        .rd_rsp      (rd_rsp),
        .rd_req      (rd_req),
        .done        (status.done),
        .rsp_count   (status.rsp_count),
        .checksum    (status.checksum)
    );

    host_chan_events #(
        .CNT_WIDTH (CNT_WIDTH)
    ) i_host_chan_events (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .start     (start),
        .accept    (accept),
        .rsp_valid (rd_rsp.readdatavalid),
        .latency   (status.latency)
    );

endmodule

// ==== host_chan_events.sv ====
//==========================================================
// Host channel event tracker
// Sums the outstanding read count over every cycle, which
// totals the latency of all requests
//==========================================================

`timescale 1ns/10ps

module host_chan_events
#(
    parameter int CNT_WIDTH = 5
)
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clear,
    input  logic        start,
    input  logic        accept,
    input  logic        rsp_valid,
    output logic [63:0] latency
);

    logic [CNT_WIDTH-1:0] outstanding;
    logic                 dec;

    // A response left over from a cleared run must not wrap the count
    assign dec = rsp_valid && (outstanding != '0);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            outstanding <= '0;
            latency     <= '0;
        end
        else if (start || clear)
        begin
            outstanding <= '0;
            latency     <= '0;
        end
        else
        begin
            outstanding <= outstanding + CNT_WIDTH'(accept) - CNT_WIDTH'(dec);
            // Count held at the start of this cycle
            latency     <= latency + 64'(outstanding);
        end
    end

endmodule

// ==== host_rd_engine.sv ====
//==========================================================
// Host read engine
// Issues single-line reads from base upward within a credit
// limit and XOR-folds returned lines into a checksum
//==========================================================

`timescale 1ns/10ps

module host_rd_engine
    import host_mem_pkg::*;
    import afu_csr_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 16
)
(
    input  logic         clk,
    input  logic         arst_n,
    input  t_rd_cfg      cfg,
    input  logic         start,
    input  logic         clear,
    input  logic         waitrequest,
    input  t_host_rd_rsp rd_rsp,
    output t_host_rd_req rd_req,
    output logic         done,
    output logic [31:0]  rsp_count,
    output logic [63:0]  checksum
);

    localparam int CREDIT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam int LANES    = LINE_DATA_WIDTH / 64;

    logic                running;
    logic [31:0]         issue_cnt;
    logic [CREDIT_W-1:0] outstanding;
    logic                accept;
    logic                rsp_in;
    logic [63:0]         line_fold;

    // Request i goes to base plus i
    assign rd_req.read    = running && (issue_cnt != cfg.count) &&
                            (outstanding < CREDIT_W'(MAX_OUTSTANDING));
    assign rd_req.address = cfg.base + t_line_addr'(issue_cnt);

    assign accept = rd_req.read && !waitrequest;
    assign rsp_in = running && rd_rsp.readdatavalid;

    always_comb
    begin
        line_fold = '0;
        for (int i = 0; i < LANES; i++)
            line_fold = line_fold ^ rd_rsp.readdata[i*64 +: 64];
    end

    // Credits follow the bus even across a clear
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            outstanding <= '0;
        else
            outstanding <= outstanding + CREDIT_W'(accept) - CREDIT_W'(rd_rsp.readdatavalid);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            running   <= 1'b0;
            done      <= 1'b0;
            issue_cnt <= '0;
            rsp_count <= '0;
            checksum  <= '0;
        end
        else if (start || clear)
        begin
            running   <= start && (cfg.count != 0);
            done      <= start && (cfg.count == 0);
            issue_cnt <= '0;
            rsp_count <= '0;
            checksum  <= '0;
        end
        else
        begin
            if (accept)
                issue_cnt <= issue_cnt + 32'd1;
            if (rsp_in)
            begin
                rsp_count <= rsp_count + 32'd1;
                checksum  <= checksum ^ line_fold;
                // Last response ends the run
                if (rsp_count + 32'd1 == cfg.count)
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== afu_csr.sv ====
//==========================================================
// MMIO register block
// Holds the base and count registers, turns control writes
// into start and clear pulses and returns status words
//==========================================================

`timescale 1ns/10ps

module afu_csr
    import host_mem_pkg::*;
    import afu_csr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  t_mmio_req  mmio_req,
    input  t_rd_status status,
    output t_mmio_rsp  mmio_rsp,
    output t_rd_cfg    cfg,
    output logic       start,
    output logic       clear
);

    t_csr_word   wr_word;
    t_line_addr  base_q;
    logic [31:0] count_q;
    logic [63:0] rd_mux;
    logic        rd_valid_q;
    logic [63:0] rd_data_q;

    assign wr_word.raw = mmio_req.writedata;

    //==========================================================
    // Register writes
    //==========================================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            base_q  <= '0;
            count_q <= '0;
            start   <= 1'b0;
            clear   <= 1'b0;
        end
        else
        begin
            // Pulses last one cycle unless rewritten
            start <= 1'b0;
            clear <= 1'b0;
            if (mmio_req.write)
            begin
                case (mmio_req.address)
                    CSR_CTRL:
                    begin
                        start <= wr_word.ctrl.start;
                        clear <= wr_word.ctrl.clear;
                    end
                    CSR_BASE:  base_q  <= wr_word.raw[LINE_ADDR_WIDTH-1:0];
                    CSR_COUNT: count_q <= wr_word.raw[31:0];
                    default:   ;
                endcase
            end
        end
    end

    assign cfg.base  = base_q;
    assign cfg.count = count_q;

    //==========================================================
    // Register reads
    //==========================================================

    always_comb
    begin
        case (mmio_req.address)
            CSR_BASE:     rd_mux = 64'(base_q);
            CSR_COUNT:    rd_mux = 64'(count_q);
            // Response count in the upper half, done in bit 0
            CSR_STATUS:   rd_mux = {status.rsp_count, 31'b0, status.done};
            CSR_CHECKSUM: rd_mux = status.checksum;
            CSR_LATENCY:  rd_mux = status.latency;
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rd_valid_q <= 1'b0;
        else
            rd_valid_q <= mmio_req.read;
    end

    always_ff @(posedge clk)
    begin
        if (mmio_req.read)
            rd_data_q <= rd_mux;
    end

    assign mmio_rsp.readdatavalid = rd_valid_q;
    assign mmio_rsp.readdata      = rd_data_q;

endmodule

// ==== afu_csr_pkg.sv ====
//==========================================================
// CSR definitions of the latency tester
// MMIO word addresses, control fields, MMIO structs and
// the configuration and status bundles
//==========================================================

package afu_csr_pkg;
    import host_mem_pkg::*;

    // 64-bit word addresses
    localparam logic [2:0] CSR_CTRL     = 3'd0;
    localparam logic [2:0] CSR_BASE     = 3'd1;
    localparam logic [2:0] CSR_COUNT    = 3'd2;
    localparam logic [2:0] CSR_STATUS   = 3'd3;
    localparam logic [2:0] CSR_CHECKSUM = 3'd4;
    localparam logic [2:0] CSR_LATENCY  = 3'd5;

    // Start is bit 0, clear is bit 1
    typedef struct packed {
        logic [61:0] rsvd;
        logic        clear;
        logic        start;
    } t_csr_ctrl;

    // A written word is either control fields or a plain value
    typedef union packed {
        logic [63:0] raw;
        t_csr_ctrl   ctrl;
    } t_csr_word;

    typedef struct packed {
        logic        write;
        logic        read;
        logic [2:0]  address;
        logic [63:0] writedata;
    } t_mmio_req;

    typedef struct packed {
        logic        readdatavalid;
        logic [63:0] readdata;
    } t_mmio_rsp;

    typedef struct packed {
        t_line_addr  base;
        logic [31:0] count;
    } t_rd_cfg;

    typedef struct packed {
        logic        done;
        logic [31:0] rsp_count;
        logic [63:0] checksum;
        logic [63:0] latency;
    } t_rd_status;

endpackage

// ==== host_mem_pkg.sv ====
//==========================================================
// Host memory channel definitions
// Line widths and the Avalon read request and response
// structs exchanged between the read engine and host memory
//==========================================================

package host_mem_pkg;

    // Host memory is addressed in whole lines
    localparam int LINE_ADDR_WIDTH = 42;
    localparam int LINE_DATA_WIDTH = 512;

    typedef logic [LINE_ADDR_WIDTH-1:0] t_line_addr;

    //==========================================================
    // Avalon read channel
    //==========================================================

    // Engine toward host memory, held stable under waitrequest
    typedef struct packed {
        t_line_addr address;
        logic       read;
    } t_host_rd_req;

    // Host memory toward engine, in order and never stalled
    typedef struct packed {
        logic [LINE_DATA_WIDTH-1:0] readdata;
        logic                       readdatavalid;
    } t_host_rd_rsp;

endpackage
